/* filelist.f */
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_store.sv
hdl/icache_refill.sv
hdl/icache_stats.sv
hdl/icache_top.sv
verification/icache_tb.sv

/* hdl/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ----------------------------------------
// Cache geometry
// ----------------------------------------

// 8 lines, direct mapped
`define ICACHE_INDEX_BITS 3
// 4 words per line
`define ICACHE_WORD_BITS 2
// Byte offset inside a 32-bit word
`define ICACHE_BYTE_BITS 2

// Top address byte of the cacheable region
`define ICACHE_REGION 8'ha0

// AXI burst encodings
`define ICACHE_BURST_FIXED 2'b00
`define ICACHE_BURST_INCR 2'b01

`endif

/* hdl/icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_ctrl (
    input  logic                clock,
    input  logic                reset,
    input  logic                ifu_arvalid,
    output logic                ifu_arready,
    input  icache_pkg::ar_req_t ifu_ar,
    output logic                ifu_rvalid,
    input  logic                ifu_rready,
    output icache_pkg::r_beat_t ifu_r,
    input  logic                tag_hit,
    input  icache_pkg::word_t   cached_word,
    input  icache_pkg::r_beat_t mem_r,
    input  logic                mem_rvalid,
    output logic                mem_rready,
    input  logic                refill_last,
    output icache_pkg::addr_t   req_addr,
    output logic                start_line,
    output logic                start_bypass,
    output logic                line_alloc,
    output logic                beat_write,
    output logic                count_hit,
    output logic                count_miss
);
    import icache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        cacheable;
    // Line is complete, requested word waits for the fetch unit
    logic        refill_done;
    logic [1:0]  fill_resp;

    assign cacheable  = (req_addr[31:24] == `ICACHE_REGION);
    assign line_alloc = start_line;
    assign beat_write = (state == REFILL) && !refill_done && mem_rvalid;

    // ----------------------------------------
    // State and request registers
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            refill_done <= 1'b0;
        end else begin
            state <= state_next;
            if (state == REFILL && refill_last) begin
                refill_done <= 1'b1;
            end else if (state_next == IDLE) begin
                refill_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ifu_arvalid && ifu_arready) begin
            req_addr <= ifu_ar.addr;
        end
        // Keep the first error seen during a line fill
        if (start_line) begin
            fill_resp <= 2'b00;
        end else if (beat_write && fill_resp == 2'b00) begin
            fill_resp <= mem_r.resp;
        end
    end

    // ----------------------------------------
    // Next state and handshake outputs
    // ----------------------------------------
    always_comb begin
        state_next   = state;
        ifu_arready  = 1'b0;
        ifu_rvalid   = 1'b0;
        ifu_r        = '{data: cached_word, resp: 2'b00, last: 1'b1};
        mem_rready   = 1'b0;
        start_line   = 1'b0;
        start_bypass = 1'b0;
        count_hit    = 1'b0;
        count_miss   = 1'b0;
        case (state)
            IDLE: begin
                ifu_arready = 1'b1;
                if (ifu_arvalid) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cacheable) begin
                    start_bypass = 1'b1;
                    state_next   = BYPASS;
                end else if (tag_hit) begin
                    count_hit  = 1'b1;
                    state_next = HIT;
                end else begin
                    start_line = 1'b1;
                    count_miss = 1'b1;
                    state_next = REFILL;
                end
            end
            HIT: begin
                ifu_rvalid = 1'b1;
                if (ifu_rready) begin
                    state_next = IDLE;
                end
            end
            REFILL: begin
                if (refill_done) begin
                    // Whole line is in the store now
                    ifu_rvalid = 1'b1;
                    ifu_r.resp = fill_resp;
                    if (ifu_rready) begin
                        state_next = IDLE;
                    end
                end else begin
                    mem_rready = 1'b1;
                end
            end
            BYPASS: begin
                ifu_rvalid = mem_rvalid;
                ifu_r      = mem_r;
                mem_rready = ifu_rready;
                if (mem_rvalid && ifu_rready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Returned beat may not change while the fetch unit stalls
    assert property (@(posedge clock) disable iff (reset)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_r))
        else $error("ifu_r changed while waiting for ifu_rready");

endmodule

/* hdl/icache_pkg.sv */
`include "icache_cfg.svh"

package icache_pkg;

    // ----------------------------------------
    // Widths with a meaning
    // ----------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`ICACHE_WORD_BITS-1:0] offset_t;
    typedef logic [31-`ICACHE_INDEX_BITS-`ICACHE_WORD_BITS-`ICACHE_BYTE_BITS:0] tag_t;
    typedef logic [31:0] count_t;

    // ----------------------------------------
    // AXI read channel payloads
    // ----------------------------------------

    // AR channel, no ID or size
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [1:0] burst;
    } ar_req_t;

    // R channel, no ID
    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } r_beat_t;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        REFILL,
        BYPASS
    } ctrl_state_e;

endpackage

/* hdl/icache_refill.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_refill (
    input  logic                clock,
    input  logic                reset,
    input  logic                start_line,
    input  logic                start_bypass,
    input  icache_pkg::addr_t   req_addr,
    output logic                mem_arvalid,
    input  logic                mem_arready,
    output icache_pkg::ar_req_t mem_ar,
    input  logic                mem_rvalid,
    input  icache_pkg::r_beat_t mem_r,
    output icache_pkg::offset_t beat_offset,
    output logic                refill_last
);
    import icache_pkg::*;

    localparam int LINE_WORDS = 1 << `ICACHE_WORD_BITS;
    localparam int LINE_LSB   = `ICACHE_WORD_BITS + `ICACHE_BYTE_BITS;

    logic    line_active;
    offset_t beat_cnt;

    // ----------------------------------------
    // AR request
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_arvalid <= 1'b0;
        end else if (start_line || start_bypass) begin
            mem_arvalid <= 1'b1;
        end else if (mem_arready) begin
            mem_arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start_line) begin
            // Whole aligned line, wrapping not needed
            mem_ar.addr  <= {req_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
            mem_ar.len   <= 8'(LINE_WORDS - 1);
            mem_ar.burst <= `ICACHE_BURST_INCR;
        end else if (start_bypass) begin
            mem_ar.addr  <= req_addr;
            mem_ar.len   <= 8'd0;
            mem_ar.burst <= `ICACHE_BURST_FIXED;
        end
    end

    // Beat counter for line refills
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_active <= 1'b0;
            beat_cnt    <= '0;
        end else if (start_line) begin
            line_active <= 1'b1;
            beat_cnt    <= '0;
        end else if (line_active && mem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (mem_r.last) begin
                line_active <= 1'b0;
            end
        end
    end

    assign beat_offset = beat_cnt;
    assign refill_last = line_active && mem_rvalid && mem_r.last;

    assert property (@(posedge clock) disable iff (reset)
        line_active && mem_rvalid |-> mem_r.last == (beat_cnt == offset_t'(LINE_WORDS - 1)))
        else $error("rlast does not match the line burst length");

endmodule

/* hdl/icache_stats.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_stats (
    input  logic               clock,
    input  logic               reset,
    input  logic               count_hit,
    input  logic               count_miss,
    output icache_pkg::count_t hit_count,
    output icache_pkg::count_t miss_count
);

    // ----------------------------------------
    // Saturating counters
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count <= '0;
        end else if (count_hit && hit_count != '1) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    // One pulse per miss, when its refill starts
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            miss_count <= '0;
        end else if (count_miss && miss_count != '1) begin
            miss_count <= miss_count + 1'b1;
        end
    end

endmodule

/* hdl/icache_store.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_store (
    input  logic                clock,
    input  logic                reset,
    input  icache_pkg::addr_t   addr,
    input  logic                line_alloc,
    input  logic                beat_write,
    input  icache_pkg::offset_t beat_offset,
    input  icache_pkg::word_t   beat_data,
    output logic                tag_hit,
    output icache_pkg::word_t   cached_word
);
    import icache_pkg::*;

    localparam int LINES      = 1 << `ICACHE_INDEX_BITS;
    localparam int LINE_WORDS = 1 << `ICACHE_WORD_BITS;
    localparam int INDEX_LSB  = `ICACHE_WORD_BITS + `ICACHE_BYTE_BITS;
    localparam int TAG_LSB    = INDEX_LSB + `ICACHE_INDEX_BITS;

    logic [LINES-1:0] valid_q;
    tag_t             tag_mem [LINES];
    word_t            data_mem [LINES][LINE_WORDS];
    index_t           index;
    offset_t          offset;
    tag_t             tag;

    // Address split
    assign index  = addr[INDEX_LSB +: `ICACHE_INDEX_BITS];
    assign offset = addr[`ICACHE_BYTE_BITS +: `ICACHE_WORD_BITS];
    assign tag    = addr[31:TAG_LSB];

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else if (line_alloc) begin
            valid_q[index] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clock) begin
        if (line_alloc) begin
            tag_mem[index] <= tag;
        end
        if (beat_write) begin
            data_mem[index][beat_offset] <= beat_data;
        end
    end

    // Combinational lookup
    assign tag_hit     = valid_q[index] && (tag_mem[index] == tag);
    assign cached_word = data_mem[index][offset];

    // Allocation happens in LOOKUP, beats only arrive in REFILL
    assert property (@(posedge clock) disable iff (reset)
        !(line_alloc && beat_write))
        else $error("line_alloc and beat_write in the same cycle");

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                ifu_arvalid,
    output logic                ifu_arready,
    input  icache_pkg::ar_req_t ifu_ar,
    output logic                ifu_rvalid,
    input  logic                ifu_rready,
    output icache_pkg::r_beat_t ifu_r,
    output logic                mem_arvalid,
    input  logic                mem_arready,
    output icache_pkg::ar_req_t mem_ar,
    input  logic                mem_rvalid,
    output logic                mem_rready,
    input  icache_pkg::r_beat_t mem_r,
    output icache_pkg::count_t  hit_count,
    output icache_pkg::count_t  miss_count
);
    import icache_pkg::*;

    addr_t   req_addr;
    word_t   cached_word;
    offset_t beat_offset;
    logic    tag_hit;
    logic    refill_last;
    logic    start_line;
    logic    start_bypass;
    logic    line_alloc;
    logic    beat_write;
    logic    count_hit;
    logic    count_miss;

    icache_ctrl ctrl0 (
        .clock        (clock),
        .reset        (reset),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_arready  (ifu_arready),
        .ifu_ar       (ifu_ar),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rready   (ifu_rready),
        .ifu_r        (ifu_r),
        .tag_hit      (tag_hit),
        .cached_word  (cached_word),
        .mem_r        (mem_r),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready),
        .refill_last  (refill_last),
        .req_addr     (req_addr),
        .start_line   (start_line),
        .start_bypass (start_bypass),
        .line_alloc   (line_alloc),
        .beat_write   (beat_write),
        .count_hit    (count_hit),
        .count_miss   (count_miss)
    );

    // Beat data comes straight from the R channel
    icache_store store0 (
        .clock       (clock),
        .reset       (reset),
        .addr        (req_addr),
        .line_alloc  (line_alloc),
        .beat_write  (beat_write),
        .beat_offset (beat_offset),
        .beat_data   (mem_r.data),
        .tag_hit     (tag_hit),
        .cached_word (cached_word)
    );

    icache_refill refill0 (
        .clock        (clock),
        .reset        (reset),
        .start_line   (start_line),
        .start_bypass (start_bypass),
        .req_addr     (req_addr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_ar       (mem_ar),
        .mem_rvalid   (mem_rvalid),
        .mem_r        (mem_r),
        .beat_offset  (beat_offset),
        .refill_last  (refill_last)
    );

    icache_stats stats0 (
        .clock      (clock),
        .reset      (reset),
        .count_hit  (count_hit),
        .count_miss (count_miss),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module icache_tb -Mdir obj_dir -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* verification/icache_tb.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int          CLK_PERIOD       = 8;
    localparam int          NUM_FETCHES      = 24;
    localparam int          CYCLES_PER_FETCH = 200;
    localparam logic [31:0] LFSR_SEED        = 32'hf26a_232d;
    localparam logic [31:0] LFSR_TAPS        = 32'h8020_0003;
    localparam word_t       DATA_MASK        = 32'h5a5a_5a5a;
    // Two tags that share line index 0
    localparam addr_t       LINE_A           = 32'ha000_0100;
    localparam addr_t       LINE_B           = 32'ha000_0180;

    logic        clock = 1'b0;
    logic        reset;
    logic        ifu_arvalid;
    logic        ifu_arready;
    ar_req_t     ifu_ar;
    logic        ifu_rvalid;
    logic        ifu_rready;
    r_beat_t     ifu_r;
    logic        mem_arvalid;
    logic        mem_arready;
    ar_req_t     mem_ar;
    logic        mem_rvalid;
    logic        mem_rready;
    r_beat_t     mem_r;
    count_t      hit_count;
    count_t      miss_count;

    // Requests seen by the memory model
    ar_req_t     req_q[$];
    logic [31:0] mem_lfsr   = LFSR_SEED;
    logic [31:0] stall_lfsr = LFSR_SEED;
    int          errors       = 0;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          exp_hits     = 0;
    int          exp_misses   = 0;

    icache_top dut0 (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ----------------------------------------
    // Reference data and random bits
    // ----------------------------------------
    function automatic word_t model_word(input addr_t addr);
        return addr ^ DATA_MASK;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic draw_mem_bit(output logic b);
        b        = mem_lfsr[0];
        mem_lfsr = lfsr_step(mem_lfsr);
    endtask

    task automatic draw_stall_bit(output logic b);
        b          = stall_lfsr[0];
        stall_lfsr = lfsr_step(stall_lfsr);
    endtask

    // ----------------------------------------
    // Checks and reporting
    // ----------------------------------------
    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    task automatic note_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        record_error();
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic compare_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic compare_req(input string name, input ar_req_t got, input ar_req_t exp);
        if (got !== exp) begin
            $display(
                "** Error at %0t ns: %s is %h len %0d burst %0d, expected %h len %0d burst %0d",
                $time, name, got.addr, got.len, got.burst, exp.addr, exp.len, exp.burst);
            record_error();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic compare_int(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic start_test();
        test_errors = 0;
        req_q.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic check_counters();
        compare_count("hit_count", hit_count, count_t'(exp_hits));
        compare_count("miss_count", miss_count, count_t'(exp_misses));
    endtask

    // ----------------------------------------
    // AXI read slave with random delays
    // ----------------------------------------
    initial begin : memory_model
        logic  burst_active;
        logic  incr;
        logic  consumed;
        logic  coin;
        addr_t beat_addr;
        int    beats_left;
        mem_arready  = 1'b0;
        mem_rvalid   = 1'b0;
        mem_r        = '0;
        burst_active = 1'b0;
        incr         = 1'b0;
        beat_addr    = '0;
        beats_left   = 0;
        forever begin
            @(posedge clock);
            consumed = 1'b0;
            if (mem_arvalid === 1'b1 && mem_arready) begin
                req_q.push_back(mem_ar);
                burst_active = 1'b1;
                incr         = (mem_ar.burst == `ICACHE_BURST_INCR);
                beat_addr    = mem_ar.addr;
                beats_left   = int'(mem_ar.len) + 1;
            end
            if (mem_rvalid && mem_rready === 1'b1) begin
                consumed = 1'b1;
                beats_left--;
                if (incr) begin
                    beat_addr = beat_addr + 32'd4;
                end
                burst_active = (beats_left > 0);
            end
            @(negedge clock);
            if (consumed) begin
                mem_rvalid = 1'b0;
            end
            draw_mem_bit(coin);
            mem_arready = coin;
            if (burst_active && !mem_rvalid) begin
                draw_mem_bit(coin);
                if (coin) begin
                    mem_rvalid = 1'b1;
                    mem_r = '{data: model_word(beat_addr), resp: 2'b00, last: (beats_left == 1)};
                end
            end
        end
    end

    // One fetch on the IFU side
    // Latency counts from the AR handshake
    task automatic fetch(input addr_t addr, input logic stall, output word_t data,
                         output int latency);
        logic    accepted;
        logic    done;
        logic    waiting;
        logic    coin;
        r_beat_t held;
        int      cycles;
        accepted = 1'b0;
        done     = 1'b0;
        waiting  = 1'b0;
        held     = '0;
        cycles   = 0;
        latency  = -1;
        data     = '0;
        @(negedge clock);
        ifu_ar      = '{addr: addr, len: 8'd0, burst: `ICACHE_BURST_INCR};
        ifu_arvalid = 1'b1;
        while (!accepted) begin
            @(posedge clock);
            accepted = (ifu_arready === 1'b1);
        end
        @(negedge clock);
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b1;
        if (stall) begin
            draw_stall_bit(coin);
            ifu_rready = coin;
        end
        while (!done) begin
            @(posedge clock);
            cycles++;
            if (waiting && (ifu_rvalid !== 1'b1 || ifu_r !== held)) begin
                note_failure($sformatf("ifu_r changed while stalled, fetch of %h", addr));
            end
            if (ifu_rvalid === 1'b1 && latency < 0) begin
                latency = cycles;
            end
            if (ifu_rvalid === 1'b1 && ifu_rready) begin
                data = ifu_r.data;
                // Single OKAY beat for every fetch
                compare_resp("ifu_r.resp", ifu_r.resp, 2'b00);
                compare_flag("ifu_r.last", ifu_r.last, 1'b1);
                done = 1'b1;
            end else begin
                waiting = (ifu_rvalid === 1'b1);
                held    = ifu_r;
                @(negedge clock);
                ifu_rready = 1'b1;
                if (stall) begin
                    draw_stall_bit(coin);
                    ifu_rready = coin;
                end
            end
        end
        @(negedge clock);
        ifu_rready = 1'b0;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic check_reset_state();
        start_test();
        compare_flag("ifu_arready", ifu_arready, 1'b1);
        compare_flag("ifu_rvalid", ifu_rvalid, 1'b0);
        compare_flag("mem_arvalid", mem_arvalid, 1'b0);
        check_counters();
        end_test("reset state");
    endtask

    task automatic miss_cold_line();
        word_t data;
        int    latency;
        start_test();
        fetch(LINE_A + 32'h8, 1'b0, data, latency);
        exp_misses++;
        compare_word("ifu_r.data", data, model_word(LINE_A + 32'h8));
        compare_int("memory requests", req_q.size(), 1);
        if (req_q.size() > 0) begin
            compare_req("mem_ar", req_q[0],
                        ar_req_t'{addr: LINE_A, len: 8'd3, burst: `ICACHE_BURST_INCR});
        end
        check_counters();
        end_test("first fetch miss");
    endtask

    task automatic hit_filled_line();
        word_t data;
        int    latency;
        addr_t addr;
        start_test();
        for (int w = 0; w < 4; w++) begin
            addr = LINE_A + addr_t'(4 * w);
            fetch(addr, 1'b0, data, latency);
            exp_hits++;
            compare_word("ifu_r.data", data, model_word(addr));
            compare_int("hit latency in cycles", latency, 2);
        end
        compare_int("memory requests", req_q.size(), 0);
        check_counters();
        end_test("hits on a filled line");
    endtask

    task automatic conflict_miss();
        word_t data;
        int    latency;
        start_test();
        fetch(LINE_B + 32'h4, 1'b0, data, latency);
        compare_word("ifu_r.data", data, model_word(LINE_B + 32'h4));
        fetch(LINE_A + 32'hc, 1'b0, data, latency);
        compare_word("ifu_r.data", data, model_word(LINE_A + 32'hc));
        exp_misses += 2;
        compare_int("memory requests", req_q.size(), 2);
        if (req_q.size() == 2) begin
            compare_req("mem_ar", req_q[0],
                        ar_req_t'{addr: LINE_B, len: 8'd3, burst: `ICACHE_BURST_INCR});
            compare_req("mem_ar", req_q[1],
                        ar_req_t'{addr: LINE_A, len: 8'd3, burst: `ICACHE_BURST_INCR});
        end
        check_counters();
        end_test("conflict miss");
    endtask

    task automatic bypass_fetch();
        word_t data;
        int    latency;
        start_test();
        fetch(32'h1234_5678, 1'b0, data, latency);
        compare_word("ifu_r.data", data, model_word(32'h1234_5678));
        compare_int("memory requests", req_q.size(), 1);
        if (req_q.size() > 0) begin
            compare_req("mem_ar", req_q[0],
                        ar_req_t'{addr: 32'h1234_5678, len: 8'd0, burst: `ICACHE_BURST_FIXED});
        end
        check_counters();
        end_test("bypass");
    endtask

    // Random bits [7:2] pick tag bit 7, index and offset
    task automatic stall_mixed_fetches();
        word_t      data;
        int         latency;
        addr_t      addr;
        logic       coin;
        logic       cached;
        logic [5:0] low_bits;
        start_test();
        for (int i = 0; i < 16; i++) begin
            draw_stall_bit(cached);
            for (int b = 0; b < 6; b++) begin
                draw_stall_bit(coin);
                low_bits[b] = coin;
            end
            addr = {cached ? 8'ha0 : 8'h3c, 16'h0000, low_bits, 2'b00};
            fetch(addr, 1'b1, data, latency);
            compare_word("ifu_r.data", data, model_word(addr));
        end
        end_test("back-pressure");
    endtask

    // ----------------------------------------
    // Watchdog and main sequence
    // ----------------------------------------
    initial begin : watchdog
        #(CLK_PERIOD * (CYCLES_PER_FETCH * NUM_FETCHES + 10));
        $display("Watchdog expired, the DUT stopped answering fetches");
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        reset       = 1'b1;
        ifu_arvalid = 1'b0;
        ifu_ar      = '0;
        ifu_rready  = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        check_reset_state();
        miss_cold_line();
        hit_filled_line();
        conflict_miss();
        bypass_fetch();
        stall_mixed_fetches();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
